/* hw/tnn_pkg.sv */
`default_nettype none

package tnn_pkg;

    // ==============================
    // dimensions
    // ==============================

    localparam int FEAT_CNT   = 16;
    localparam int FEAT_BITS  = 4;
    localparam int HIDDEN_CNT = 16;
    localparam int CLASS_CNT  = 10;
    localparam int ACC_BITS   = 10;
    // largest score is 2*16 + 7 = 39
    localparam int SCORE_BITS = 6;
    localparam int CLASS_BITS = 4;

    typedef logic [FEAT_BITS-1:0]    feature_t;
    typedef feature_t [FEAT_CNT-1:0] feature_vec_t;
    typedef logic [HIDDEN_CNT-1:0]   hidden_t;
    typedef logic [SCORE_BITS-1:0]   score_t;
    typedef score_t [CLASS_CNT-1:0]  score_vec_t;
    typedef logic [CLASS_BITS-1:0]   class_t;

    // ==============================
    // hidden layer weights
    // ==============================

    // bit f of entry n set means feature f adds to neuron n
    localparam logic [FEAT_CNT-1:0] HIDDEN_POS_MASK [HIDDEN_CNT] = '{
        16'h5049,
        16'hB203,
        16'h105A,
        16'hEF85,
        16'h001A,
        16'hA026,
        16'h1601,
        16'hAC06,
        16'h4AC0,
        16'h1058,
        16'hF813,
        16'h400E,
        16'h4168,
        16'hA180,
        16'hE8F4,
        16'h4A00
    };

    // bit f of entry n set means feature f subtracts from neuron n
    localparam logic [FEAT_CNT-1:0] HIDDEN_NEG_MASK [HIDDEN_CNT] = '{
        16'hAD24,
        16'h4140,
        16'hEA25,
        16'h105A,
        16'hA085,
        16'h4EC0,
        16'hE940,
        16'h5088,
        16'hB031,
        16'hE8A5,
        16'h03A4,
        16'h9710,
        16'hBE03,
        16'h4800,
        16'h050B,
        16'hB081
    };

    // ==============================
    // output layer weights
    // ==============================

    // a hidden bit of 1 under a positive weight counts as a match
    localparam logic [HIDDEN_CNT-1:0] CLASS_POS_MASK [CLASS_CNT] = '{
        16'h048A,
        16'hD100,
        16'hD915,
        16'h9256,
        16'h8C08,
        16'h4082,
        16'h0CE2,
        16'h5014,
        16'h6000,
        16'h0048
    };

    // a hidden bit of 0 under a negative weight counts as a match
    localparam logic [HIDDEN_CNT-1:0] CLASS_NEG_MASK [CLASS_CNT] = '{
        16'h5934,
        16'h06E3,
        16'h20EA,
        16'h4529,
        16'h6024,
        16'h9605,
        16'hD100,
        16'h00C9,
        16'h8950,
        16'h90B0
    };

    localparam score_t CLASS_BIAS [CLASS_CNT] = '{
        6'd3, 6'd3, 6'd3, 6'd3, 6'd0, 6'd7, 6'd0, 6'd7, 6'd0, 6'd6
    };

endpackage

`default_nettype wire

/* hw/hidden_layer.sv */
`timescale 1ns/100ps
`default_nettype none

module hidden_layer (
    input  tnn_pkg::feature_vec_t features,
    output tnn_pkg::hidden_t      hidden
);
    import tnn_pkg::*;

    // signed sum of the selected features, features are zero extended first
    function automatic logic signed [ACC_BITS-1:0] neuron_sum(
        input feature_vec_t          fv,
        input logic [FEAT_CNT-1:0]   pos,
        input logic [FEAT_CNT-1:0]   neg
    );
        logic signed [ACC_BITS-1:0] acc;
        logic signed [ACC_BITS-1:0] term;
        acc = '0;
        for (int f = 0; f < FEAT_CNT; f++) begin
            term = signed'(ACC_BITS'(fv[f]));
            if (pos[f]) begin
                acc = acc + term;
            end
            if (neg[f]) begin
                acc = acc - term;
            end
        end
        return acc;
    endfunction

    for (genvar n = 0; n < HIDDEN_CNT; n++) begin : g_neuron
        logic signed [ACC_BITS-1:0] sum;

        assign sum = neuron_sum(features, HIDDEN_POS_MASK[n], HIDDEN_NEG_MASK[n]);
        // sign activation, a zero sum fires
        assign hidden[n] = (sum >= 0);
    end

endmodule

`default_nettype wire

/* hw/pipe_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module pipe_stage #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     valid_in,
    input  payload_t data_in,
    output logic     valid_out,
    output payload_t data_out
);

    // ==============================
    // stage registers
    // ==============================

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_out <= 1'b0;
            data_out  <= '0;
        end else begin
            valid_out <= valid_in;
            data_out  <= data_in;
        end
    end

    // the strobe drives the next stage without qualification
    valid_known_a: assert property (
        @(posedge clk) disable iff (!arst_n)
        !$isunknown(valid_out)
    ) else $error("valid_out unknown out of reset");

endmodule

`default_nettype wire

/* hw/class_scorer.sv */
`timescale 1ns/100ps
`default_nettype none

module class_scorer (
    input  tnn_pkg::hidden_t    hidden,
    output tnn_pkg::score_vec_t scores
);
    import tnn_pkg::*;

    function automatic int max_bias();
        int m;
        m = 0;
        for (int c = 0; c < CLASS_CNT; c++) begin
            if (int'(CLASS_BIAS[c]) > m) begin
                m = int'(CLASS_BIAS[c]);
            end
        end
        return m;
    endfunction

    localparam int MAX_SCORE = 2 * HIDDEN_CNT + max_bias();

    // every hidden bit matching its weight sign, with the bias on top
    if (MAX_SCORE >= 2 ** SCORE_BITS) begin : g_score_width_check
        $error("score width %0d cannot hold score %0d", SCORE_BITS, MAX_SCORE);
    end

    for (genvar c = 0; c < CLASS_CNT; c++) begin : g_class
        logic [HIDDEN_CNT-1:0] match;
        score_t                count;

        // ones under positive weights and zeros under negative weights
        assign match = (hidden & CLASS_POS_MASK[c]) | (~hidden & CLASS_NEG_MASK[c]);
        assign count = SCORE_BITS'($countones(match));

        assign scores[c] = (count << 1) + CLASS_BIAS[c];
    end

endmodule

`default_nettype wire

/* hw/argmax_select.sv */
`timescale 1ns/100ps
`default_nettype none

module argmax_select (
    input  tnn_pkg::score_vec_t scores,
    output tnn_pkg::class_t     prediction
);
    import tnn_pkg::*;

    // ==============================
    // linear scan
    // ==============================

    // strict compare keeps the lower index on a tie
    always_comb begin
        score_t best;
        best       = scores[0];
        prediction = '0;
        for (int c = 1; c < CLASS_CNT; c++) begin
            if (scores[c] > best) begin
                best       = scores[c];
                prediction = class_t'(c);
            end
        end
    end

endmodule

`default_nettype wire

/* hw/tnn_classifier.sv */
`timescale 1ns/100ps
`default_nettype none

module tnn_classifier (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  in_valid,
    input  tnn_pkg::feature_vec_t features,
    output logic                  out_valid,
    output tnn_pkg::class_t       prediction
);
    import tnn_pkg::*;

    hidden_t    hidden_comb;
    hidden_t    hidden_q;
    logic       hidden_valid;
    score_vec_t scores_comb;
    score_vec_t scores_q;

    // ==============================
    // stage 1 hidden layer
    // ==============================

    hidden_layer u_hidden (
        .features (features),
        .hidden   (hidden_comb)
    );

    pipe_stage #(
        .payload_t (hidden_t)
    ) u_hidden_stage (
        .clk       (clk),
        .arst_n    (arst_n),
        .valid_in  (in_valid),
        .data_in   (hidden_comb),
        .valid_out (hidden_valid),
        .data_out  (hidden_q)
    );

    // ==============================
    // stage 2 output layer
    // ==============================

    class_scorer u_scorer (
        .hidden (hidden_q),
        .scores (scores_comb)
    );

    pipe_stage #(
        .payload_t (score_vec_t)
    ) u_score_stage (
        .clk       (clk),
        .arst_n    (arst_n),
        .valid_in  (hidden_valid),
        .data_in   (scores_comb),
        .valid_out (out_valid),
        .data_out  (scores_q)
    );

    // selection is combinational after the second register
    argmax_select u_argmax (
        .scores     (scores_q),
        .prediction (prediction)
    );

    prediction_range_a: assert property (
        @(posedge clk) disable iff (!arst_n)
        out_valid |-> (prediction < CLASS_CNT)
    ) else $error("prediction %0d out of class range", prediction);

endmodule

`default_nettype wire

/* test/tnn_model.svh */
`ifndef TNN_MODEL_SVH
`define TNN_MODEL_SVH

// sign of each ternary dot product, computed with plain integers
function automatic tnn_pkg::hidden_t model_hidden(input tnn_pkg::feature_vec_t fv);
    tnn_pkg::hidden_t h;
    int               sum;
    for (int n = 0; n < tnn_pkg::HIDDEN_CNT; n++) begin
        sum = 0;
        for (int f = 0; f < tnn_pkg::FEAT_CNT; f++) begin
            if (tnn_pkg::HIDDEN_POS_MASK[n][f]) begin
                sum += int'(fv[f]);
            end
            if (tnn_pkg::HIDDEN_NEG_MASK[n][f]) begin
                sum -= int'(fv[f]);
            end
        end
        h[n] = (sum >= 0);
    end
    return h;
endfunction

function automatic int model_score(input tnn_pkg::hidden_t h, input int c);
    int count;
    count = 0;
    for (int n = 0; n < tnn_pkg::HIDDEN_CNT; n++) begin
        if (tnn_pkg::CLASS_POS_MASK[c][n] && h[n]) begin
            count++;
        end
        if (tnn_pkg::CLASS_NEG_MASK[c][n] && !h[n]) begin
            count++;
        end
    end
    return 2 * count + int'(tnn_pkg::CLASS_BIAS[c]);
endfunction

// highest score wins, first one found on a tie
function automatic tnn_pkg::class_t model_predict(input tnn_pkg::feature_vec_t fv);
    tnn_pkg::hidden_t h;
    int               best;
    int               best_idx;
    h        = model_hidden(fv);
    best     = model_score(h, 0);
    best_idx = 0;
    for (int c = 1; c < tnn_pkg::CLASS_CNT; c++) begin
        if (model_score(h, c) > best) begin
            best     = model_score(h, c);
            best_idx = c;
        end
    end
    return tnn_pkg::class_t'(best_idx);
endfunction

`endif

/* test/tb_tnn_classifier.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_tnn_classifier;
    import tnn_pkg::*;

    `include "tnn_model.svh"

    // one vector for zero features, two random runs, 18 extreme vectors
    localparam int TOTAL_VECTORS = 1 + 200 + 200 + 18;
    localparam int CYCLE_LIMIT   = 10 + TOTAL_VECTORS * 3 + 50;

    logic         clk;
    logic         arst_n;
    logic         in_valid;
    feature_vec_t features;
    logic         out_valid;
    class_t       prediction;

    logic [31:0]  rng_state;
    class_t       exp_q[$];
    logic [1:0]   valid_hist;
    int           err_count;
    int           input_count;
    int           result_count;
    int           cycle_count;
    int           tests_passed;
    int           tests_failed;

    tnn_classifier uut (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_valid   (in_valid),
        .features   (features),
        .out_valid  (out_valid),
        .prediction (prediction)
    );

    always #2 clk = ~clk;

    // ==============================
    // helpers
    // ==============================

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic feature_vec_t random_vector();
        logic [31:0] lo;
        logic [31:0] hi;
        lo = next_random();
        hi = next_random();
        return {hi, lo};
    endfunction

    task automatic check_class(input string name, input class_t exp, input class_t act);
        if (act !== exp) begin
            $display("error at %0t: %s expected %0d, got %0d", $time, name, exp, act);
            err_count++;
        end
    endtask

    task automatic check_valid(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("error at %0t: %s expected %b, got %b", $time, name, exp, act);
            err_count++;
        end
    endtask

    task automatic drive_vector(input feature_vec_t fv);
        @(posedge clk);
        in_valid <= 1'b1;
        features <= fv;
        exp_q.push_back(model_predict(fv));
        input_count++;
    endtask

    task automatic drive_idle();
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    // the last vector is out of the second stage before the third edge after in_valid drops
    task automatic drain_pipeline();
        drive_idle();
        repeat (4) @(posedge clk);
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (err_count == errs_before) begin
            $display("test %s: pass", name);
            tests_passed++;
        end else begin
            $display("test %s: fail with %0d errors", name, err_count - errs_before);
            tests_failed++;
        end
    endtask

    // ==============================
    // output monitor
    // ==============================

    // out_valid is expected to repeat in_valid two edges later
    always @(negedge clk) begin
        check_valid("out_valid", valid_hist[1], out_valid);
        if (out_valid === 1'b1) begin
            result_count++;
            if (exp_q.size() == 0) begin
                $display("out_valid high at %0t with no vector in flight", $time);
                err_count++;
            end else begin
                check_class("prediction", exp_q.pop_front(), prediction);
            end
        end
        valid_hist[1] = valid_hist[0];
        valid_hist[0] = in_valid;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, the run did not complete", cycle_count);
            $display("Test failures found");
            $finish;
        end
    end

    // ==============================
    // stimulus
    // ==============================

    initial begin
        int           errs;
        int           inputs_before;
        int           results_before;
        logic [31:0]  r;
        feature_vec_t fv;
        $timeformat(-9, 1, " ns", 0);
        clk          = 1'b0;
        arst_n       = 1'b0;
        in_valid     = 1'b0;
        features     = '0;
        rng_state    = 32'd41;
        valid_hist   = '0;
        err_count    = 0;
        input_count  = 0;
        result_count = 0;
        cycle_count  = 0;
        tests_passed = 0;
        tests_failed = 0;

        errs = err_count;
        repeat (10) @(posedge clk);
        arst_n <= 1'b1;
        repeat (5) @(posedge clk);
        report_test("reset", errs);

        errs = err_count;
        drive_vector('0);
        drain_pipeline();
        report_test("zero features", errs);

        errs = err_count;
        repeat (200) drive_vector(random_vector());
        drain_pipeline();
        report_test("back to back stream", errs);

        errs           = err_count;
        inputs_before  = input_count;
        results_before = result_count;
        repeat (200) begin
            r = next_random();
            if (r[3]) begin
                drive_vector(random_vector());
            end else begin
                drive_idle();
            end
        end
        drain_pipeline();
        if (result_count - results_before != input_count - inputs_before) begin
            $display("random gaps gave %0d results for %0d inputs",
                     result_count - results_before, input_count - inputs_before);
            err_count++;
        end
        report_test("random gaps", errs);

        errs = err_count;
        drive_vector({FEAT_CNT{4'hF}});
        drive_vector({(FEAT_CNT / 2){4'hF, 4'h0}});
        for (int p = 0; p < FEAT_CNT; p++) begin
            fv    = '0;
            fv[p] = 4'hF;
            drive_vector(fv);
        end
        drain_pipeline();
        report_test("extreme vectors", errs);

        if (exp_q.size() != 0) begin
            $display("%0d expected results never came out of the pipeline", exp_q.size());
            err_count++;
        end
        $display("tests passed %0d, tests failed %0d, errors %0d",
                 tests_passed, tests_failed, err_count);
        if (err_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
+incdir+test
hw/tnn_pkg.sv
hw/hidden_layer.sv
hw/pipe_stage.sv
hw/class_scorer.sv
hw/argmax_select.sv
hw/tnn_classifier.sv
test/tb_tnn_classifier.sv

/* Makefile */
TOP := tb_tnn_classifier

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir
